//--- rtl/rvv_cmd_queue.sv
// command queue: circular buffer of vector commands with full level and pop strobe
`timescale 1ns/1ps

module rvv_cmd_queue
  import rvv_decode_pkg::*;
#(
  parameter int CQ_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cmd_valid,
  input  rvv_inst_u               cmd_inst,
  input  logic [1:0]              cmd_vlmul,
  input  logic [1:0]              cmd_vsew,
  input  logic [VSTART_WIDTH-1:0] cmd_vstart,
  input  logic [31:0]             cmd_rs1_data,
  input  logic                    cq_pop,
  output logic                    head_valid,
  output logic                    cq_full,
  output rvv_inst_u               head_inst,
  output logic [1:0]              head_vlmul,
  output logic [1:0]              head_vsew,
  output logic [VSTART_WIDTH-1:0] head_vstart,
  output logic [31:0]             head_rs1_data
);

  localparam int PTR_W = (CQ_DEPTH > 1) ? $clog2(CQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(CQ_DEPTH + 1);

  // command storage, one array per field
  rvv_inst_u               mem_inst     [CQ_DEPTH];
  logic [1:0]              mem_vlmul    [CQ_DEPTH];
  logic [1:0]              mem_vsew     [CQ_DEPTH];
  logic [VSTART_WIDTH-1:0] mem_vstart   [CQ_DEPTH];
  logic [31:0]             mem_rs1_data [CQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // writes while full are dropped
  assign wr_en = cmd_valid & ~cq_full;
  assign rd_en = cq_pop & head_valid;

  assign head_valid = (count != '0);
  assign cq_full    = (count == CNT_W'(CQ_DEPTH));

  // head is visible straight from storage
  assign head_inst     = mem_inst[rd_ptr];
  assign head_vlmul    = mem_vlmul[rd_ptr];
  assign head_vsew     = mem_vsew[rd_ptr];
  assign head_vstart   = mem_vstart[rd_ptr];
  assign head_rs1_data = mem_rs1_data[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_inst[wr_ptr]     <= cmd_inst;
      mem_vlmul[wr_ptr]    <= cmd_vlmul;
      mem_vsew[wr_ptr]     <= cmd_vsew;
      mem_vstart[wr_ptr]   <= cmd_vstart;
      mem_rs1_data[wr_ptr] <= cmd_rs1_data;
    end
  end

  // pointers wrap at CQ_DEPTH, not only at powers of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(CQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(CQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

endmodule

//--- rtl/rvv_decode_ctrl.sv
// decode control: uop index bookkeeping, valid gating, command retire and discard
`timescale 1ns/1ps

module rvv_decode_ctrl
  import rvv_decode_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       head_valid,
  input  logic                       uq_room,
  input  logic [NUM_DE_UOP-1:0]      dec_uop_valid,
  input  logic [NUM_DE_UOP-1:0]      dec_last,
  output logic [UOP_INDEX_WIDTH-1:0] uop_index_remain,
  output logic                       cq_pop,
  output logic                       inst_discard,
  output logic [NUM_DE_UOP-1:0]      uop_valid
);

  logic                       any_valid;
  logic                       accept;
  logic                       last_accept;
  logic [UOP_INDEX_WIDTH-1:0] num_accept;

  assign any_valid = |dec_uop_valid;

  // slots are accepted as a group whenever the uops queue has room
  assign accept      = head_valid & uq_room & any_valid;
  assign last_accept = accept & |(dec_uop_valid & dec_last);

  // valid slots are contiguous, so the count is the advance
  assign num_accept = UOP_INDEX_WIDTH'($countones(dec_uop_valid));

  // nothing leaves while the uops queue is full
  assign uop_valid = dec_uop_valid & {NUM_DE_UOP{uq_room}};

  // a head with no legal uop is dropped at once, no trap
  assign inst_discard = head_valid & ~any_valid;

  // retire after the last uop, or drop the bad command
  assign cq_pop = last_accept | inst_discard;

  always_ff @(posedge clk) begin
    if (rst) begin
      uop_index_remain <= '0;
    end else if (last_accept) begin
      // next command starts from uop 0
      uop_index_remain <= '0;
    end else if (accept) begin
      uop_index_remain <= uop_index_remain + num_accept;
    end
  end

endmodule

//--- rtl/rvv_decode_pkg.sv
// opcodes, funct codes, instruction word union, uop type enum, decode width constants
package rvv_decode_pkg;

  // uops leaving the decoder per cycle
  parameter int NUM_DE_UOP      = 4;
  // uops one instruction may expand into
  parameter int MAX_UOP         = 8;
  parameter int UOP_INDEX_WIDTH = 3;
  parameter int VSTART_WIDTH    = 7;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    LOAD  = 7'h07,
    STORE = 7'h27,
    RVV   = 7'h57
  } rvv_opcode_e;

  // OP-V funct3 categories
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPIVX = 3'b100;

  // funct6 of the supported arithmetic ops
  localparam logic [5:0] VADD   = 6'b000000;
  localparam logic [5:0] VSUB   = 6'b000010;
  localparam logic [5:0] VAND   = 6'b001001;
  localparam logic [5:0] VOR    = 6'b001010;
  localparam logic [5:0] VXOR   = 6'b001011;
  localparam logic [5:0] VWADDU = 6'b110000;

  // one instruction word, read as OP-V arithmetic or as vector load/store
  typedef union packed {
    struct packed {
      logic [5:0] funct6;
      logic       vm;
      logic [4:0] vs2;
      // vs1 index, rs1 index or imm5 depending on funct3
      logic [4:0] vs1;
      logic [2:0] funct3;
      logic [4:0] vd;
      logic [6:0] opcode;
    } ari;
    struct packed {
      // segment fields minus one
      logic [2:0] nf;
      logic       mew;
      logic [1:0] mop;
      logic       vm;
      // lumop for unit stride, rs2 otherwise
      logic [4:0] lumop;
      logic [4:0] rs1;
      logic [2:0] width;
      // vd for loads, vs3 for stores
      logic [4:0] vd;
      logic [6:0] opcode;
    } ls;
  } rvv_inst_u;

  // kind of work a uop carries
  typedef enum logic [2:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_OR,
    UOP_XOR,
    UOP_WADDU,
    UOP_LOAD,
    UOP_STORE
  } uop_type_e;

endpackage

//--- rtl/rvv_decode_top.sv
// decode stage top: command queue, decode unit and decode control
`timescale 1ns/1ps

module rvv_decode_top
  import rvv_decode_pkg::*;
#(
  parameter int CQ_DEPTH = 4,
  parameter int VLEN     = 128
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       cmd_valid,
  input  rvv_inst_u                                  cmd_inst,
  input  logic [1:0]                                 cmd_vlmul,
  input  logic [1:0]                                 cmd_vsew,
  input  logic [VSTART_WIDTH-1:0]                    cmd_vstart,
  input  logic [31:0]                                cmd_rs1_data,
  input  logic                                       uq_room,
  output logic [NUM_DE_UOP-1:0]                      uop_valid,
  output uop_type_e [NUM_DE_UOP-1:0]                 uop_type,
  output logic [NUM_DE_UOP-1:0][UOP_INDEX_WIDTH-1:0] uop_index,
  output logic [NUM_DE_UOP-1:0][4:0]                 vd,
  output logic [NUM_DE_UOP-1:0][4:0]                 vs1,
  output logic [NUM_DE_UOP-1:0][4:0]                 vs2,
  output logic [NUM_DE_UOP-1:0][31:0]                uop_rs1_data,
  output logic [NUM_DE_UOP-1:0]                      vm,
  output logic [NUM_DE_UOP-1:0][VSTART_WIDTH-1:0]    uop_vstart,
  output logic [NUM_DE_UOP-1:0]                      last,
  output logic                                       inst_discard,
  output logic                                       cq_full
);

  // queue head
  logic                       head_valid;
  rvv_inst_u                  head_inst;
  logic [1:0]                 head_vlmul;
  logic [1:0]                 head_vsew;
  logic [VSTART_WIDTH-1:0]    head_vstart;
  logic [31:0]                head_rs1_data;

  // control and ungated decoder valids
  logic                       cq_pop;
  logic [UOP_INDEX_WIDTH-1:0] uop_index_remain;
  logic [NUM_DE_UOP-1:0]      dec_uop_valid;

  rvv_cmd_queue #(.CQ_DEPTH(CQ_DEPTH)) u_cmd_queue (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_inst(cmd_inst),
    .cmd_vlmul(cmd_vlmul), .cmd_vsew(cmd_vsew), .cmd_vstart(cmd_vstart),
    .cmd_rs1_data(cmd_rs1_data), .cq_pop(cq_pop), .head_valid(head_valid),
    .cq_full(cq_full), .head_inst(head_inst), .head_vlmul(head_vlmul),
    .head_vsew(head_vsew), .head_vstart(head_vstart), .head_rs1_data(head_rs1_data)
  );

  rvv_decode_unit #(.VLEN(VLEN)) u_decode_unit (
    .inst_valid(head_valid), .inst(head_inst), .vlmul(head_vlmul), .vsew(head_vsew),
    .vstart(head_vstart), .rs1_data(head_rs1_data), .uop_index_remain(uop_index_remain),
    .uop_valid(dec_uop_valid), .uop_type(uop_type), .uop_index(uop_index),
    .vd(vd), .vs1(vs1), .vs2(vs2), .uop_rs1_data(uop_rs1_data),
    .vm(vm), .uop_vstart(uop_vstart), .last(last)
  );

  rvv_decode_ctrl u_decode_ctrl (
    .clk(clk), .rst(rst), .head_valid(head_valid), .uq_room(uq_room),
    .dec_uop_valid(dec_uop_valid), .dec_last(last),
    .uop_index_remain(uop_index_remain), .cq_pop(cq_pop),
    .inst_discard(inst_discard), .uop_valid(uop_valid)
  );

endmodule

//--- rtl/rvv_decode_unit.sv
// decode unit: opcode steering to the arithmetic and load/store decoders, output select
`timescale 1ns/1ps

module rvv_decode_unit
  import rvv_decode_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic                                       inst_valid,
  input  rvv_inst_u                                  inst,
  input  logic [1:0]                                 vlmul,
  input  logic [1:0]                                 vsew,
  input  logic [VSTART_WIDTH-1:0]                    vstart,
  input  logic [31:0]                                rs1_data,
  input  logic [UOP_INDEX_WIDTH-1:0]                 uop_index_remain,
  output logic [NUM_DE_UOP-1:0]                      uop_valid,
  output uop_type_e [NUM_DE_UOP-1:0]                 uop_type,
  output logic [NUM_DE_UOP-1:0][UOP_INDEX_WIDTH-1:0] uop_index,
  output logic [NUM_DE_UOP-1:0][4:0]                 vd,
  output logic [NUM_DE_UOP-1:0][4:0]                 vs1,
  output logic [NUM_DE_UOP-1:0][4:0]                 vs2,
  output logic [NUM_DE_UOP-1:0][31:0]                uop_rs1_data,
  output logic [NUM_DE_UOP-1:0]                      vm,
  output logic [NUM_DE_UOP-1:0][VSTART_WIDTH-1:0]    uop_vstart,
  output logic [NUM_DE_UOP-1:0]                      last
);

  rvv_opcode_e opcode;
  logic        valid_ari;
  logic        valid_lsu;

  // decoder results
  logic [NUM_DE_UOP-1:0]                      ari_valid, lsu_valid;
  uop_type_e [NUM_DE_UOP-1:0]                 ari_type, lsu_type;
  logic [NUM_DE_UOP-1:0][UOP_INDEX_WIDTH-1:0] ari_index, lsu_index;
  logic [NUM_DE_UOP-1:0][4:0]                 ari_vd, lsu_vd;
  logic [NUM_DE_UOP-1:0][4:0]                 ari_vs1, lsu_vs1;
  logic [NUM_DE_UOP-1:0][4:0]                 ari_vs2, lsu_vs2;
  logic [NUM_DE_UOP-1:0][31:0]                ari_rs1, lsu_rs1;
  logic [NUM_DE_UOP-1:0]                      ari_vm, lsu_vm;
  logic [NUM_DE_UOP-1:0][VSTART_WIDTH-1:0]    ari_vstart, lsu_vstart;
  logic [NUM_DE_UOP-1:0]                      ari_last, lsu_last;

  // opcode sits at the same bits in both formats
  assign opcode    = rvv_opcode_e'(inst.ari.opcode);
  assign valid_lsu = inst_valid & ((opcode == LOAD) | (opcode == STORE));
  assign valid_ari = inst_valid & (opcode == RVV);

  rvv_decode_unit_lsu #(.VLEN(VLEN)) u_lsu_decode (
    .inst_valid(valid_lsu), .inst(inst), .vlmul(vlmul), .vstart(vstart),
    .rs1_data(rs1_data), .uop_index_remain(uop_index_remain),
    .uop_valid(lsu_valid), .uop_type(lsu_type), .uop_index(lsu_index),
    .vd(lsu_vd), .vs1(lsu_vs1), .vs2(lsu_vs2), .uop_rs1_data(lsu_rs1),
    .vm(lsu_vm), .uop_vstart(lsu_vstart), .last(lsu_last)
  );

  rvv_decode_unit_ari #(.VLEN(VLEN)) u_ari_decode (
    .inst_valid(valid_ari), .inst(inst), .vlmul(vlmul), .vsew(vsew), .vstart(vstart),
    .rs1_data(rs1_data), .uop_index_remain(uop_index_remain),
    .uop_valid(ari_valid), .uop_type(ari_type), .uop_index(ari_index),
    .vd(ari_vd), .vs1(ari_vs1), .vs2(ari_vs2), .uop_rs1_data(ari_rs1),
    .vm(ari_vm), .uop_vstart(ari_vstart), .last(ari_last)
  );

  // unknown opcodes fall through with no valid uop
  assign uop_valid    = valid_lsu ? lsu_valid  : (valid_ari ? ari_valid : '0);
  assign uop_type     = valid_lsu ? lsu_type   : ari_type;
  assign uop_index    = valid_lsu ? lsu_index  : ari_index;
  assign vd           = valid_lsu ? lsu_vd     : ari_vd;
  assign vs1          = valid_lsu ? lsu_vs1    : ari_vs1;
  assign vs2          = valid_lsu ? lsu_vs2    : ari_vs2;
  assign uop_rs1_data = valid_lsu ? lsu_rs1    : ari_rs1;
  assign vm           = valid_lsu ? lsu_vm     : ari_vm;
  assign uop_vstart   = valid_lsu ? lsu_vstart : ari_vstart;
  assign last         = valid_lsu ? lsu_last   : ari_last;

endmodule

//--- rtl/rvv_decode_unit_ari.sv
// arithmetic decoder: legality, uop count and four uop slots from the remaining index
`timescale 1ns/1ps

module rvv_decode_unit_ari
  import rvv_decode_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic                                       inst_valid,
  input  rvv_inst_u                                  inst,
  input  logic [1:0]                                 vlmul,
  input  logic [1:0]                                 vsew,
  input  logic [VSTART_WIDTH-1:0]                    vstart,
  input  logic [31:0]                                rs1_data,
  input  logic [UOP_INDEX_WIDTH-1:0]                 uop_index_remain,
  output logic [NUM_DE_UOP-1:0]                      uop_valid,
  output uop_type_e [NUM_DE_UOP-1:0]                 uop_type,
  output logic [NUM_DE_UOP-1:0][UOP_INDEX_WIDTH-1:0] uop_index,
  output logic [NUM_DE_UOP-1:0][4:0]                 vd,
  output logic [NUM_DE_UOP-1:0][4:0]                 vs1,
  output logic [NUM_DE_UOP-1:0][4:0]                 vs2,
  output logic [NUM_DE_UOP-1:0][31:0]                uop_rs1_data,
  output logic [NUM_DE_UOP-1:0]                      vm,
  output logic [NUM_DE_UOP-1:0][VSTART_WIDTH-1:0]    uop_vstart,
  output logic [NUM_DE_UOP-1:0]                      last
);

  logic                     is_int_form;
  logic                     is_int_op;
  logic                     is_wide;
  logic                     legal;
  logic [UOP_INDEX_WIDTH:0] uop_cnt;
  uop_type_e                op_type;
  logic [31:0]              elem_per_reg;
  logic [31:0]              scalar;

  // vv, vx and vi of the plain integer ops
  assign is_int_form = inst.ari.funct3 inside {OPIVV, OPIVX, OPIVI};
  assign is_int_op   = inst.ari.funct6 inside {VADD, VSUB, VAND, VOR, VXOR};
  // vwaddu exists only as OPMVV
  assign is_wide     = (inst.ari.funct3 == OPMVV) && (inst.ari.funct6 == VWADDU);

  // widening needs 2*LMUL destination registers, so LMUL 8 has no room
  assign legal = (is_int_form & is_int_op) | (is_wide & (vlmul != 2'd3));

  // LMUL uops, doubled for the widening op
  assign uop_cnt = is_wide ? ((UOP_INDEX_WIDTH + 1)'(2) << vlmul) :
                             ((UOP_INDEX_WIDTH + 1)'(1) << vlmul);

  // elements per register at SEW
  assign elem_per_reg = 32'(VLEN) >> (32'd3 + 32'(vsew));

  // vi carries a sign-extended imm5, vx the scalar register
  assign scalar = (inst.ari.funct3 == OPIVI) ?
                  {{27{inst.ari.vs1[4]}}, inst.ari.vs1} : rs1_data;

  always_comb begin
    case (inst.ari.funct6)
      VSUB:    op_type = UOP_SUB;
      VAND:    op_type = UOP_AND;
      VOR:     op_type = UOP_OR;
      VXOR:    op_type = UOP_XOR;
      VWADDU:  op_type = UOP_WADDU;
      default: op_type = UOP_ADD;
    endcase
  end

  always_comb begin
    logic [UOP_INDEX_WIDTH:0] idx;
    logic [UOP_INDEX_WIDTH:0] src_k;
    logic [31:0]              offset;
    for (int s = 0; s < NUM_DE_UOP; s++) begin
      // uop k of the instruction sits in slot k - remain
      idx    = (UOP_INDEX_WIDTH + 1)'(uop_index_remain) + (UOP_INDEX_WIDTH + 1)'(s);
      // widening sources advance every second uop
      src_k  = is_wide ? (idx >> 1) : idx;
      offset = 32'(idx) * elem_per_reg;

      uop_valid[s]    = inst_valid & legal & (idx < uop_cnt);
      uop_type[s]     = op_type;
      uop_index[s]    = idx[UOP_INDEX_WIDTH-1:0];
      vd[s]           = inst.ari.vd + 5'(idx);
      vs2[s]          = inst.ari.vs2 + 5'(src_k);
      // vs1 is a register group only in vector-vector forms
      vs1[s]          = ((inst.ari.funct3 == OPIVV) || is_wide) ?
                        inst.ari.vs1 + 5'(src_k) : inst.ari.vs1;
      uop_rs1_data[s] = scalar;
      vm[s]           = inst.ari.vm;
      // clamp at zero once vstart falls behind this register
      uop_vstart[s]   = (32'(vstart) > offset) ?
                        VSTART_WIDTH'(32'(vstart) - offset) : '0;
      last[s]         = (idx == uop_cnt - 1'b1);
    end
  end

endmodule

//--- rtl/rvv_decode_unit_lsu.sv
// load/store decoder: unit-stride segment check, uop count and four uop slots
`timescale 1ns/1ps

module rvv_decode_unit_lsu
  import rvv_decode_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic                                       inst_valid,
  input  rvv_inst_u                                  inst,
  input  logic [1:0]                                 vlmul,
  input  logic [VSTART_WIDTH-1:0]                    vstart,
  input  logic [31:0]                                rs1_data,
  input  logic [UOP_INDEX_WIDTH-1:0]                 uop_index_remain,
  output logic [NUM_DE_UOP-1:0]                      uop_valid,
  output uop_type_e [NUM_DE_UOP-1:0]                 uop_type,
  output logic [NUM_DE_UOP-1:0][UOP_INDEX_WIDTH-1:0] uop_index,
  output logic [NUM_DE_UOP-1:0][4:0]                 vd,
  output logic [NUM_DE_UOP-1:0][4:0]                 vs1,
  output logic [NUM_DE_UOP-1:0][4:0]                 vs2,
  output logic [NUM_DE_UOP-1:0][31:0]                uop_rs1_data,
  output logic [NUM_DE_UOP-1:0]                      vm,
  output logic [NUM_DE_UOP-1:0][VSTART_WIDTH-1:0]    uop_vstart,
  output logic [NUM_DE_UOP-1:0]                      last
);

  logic       is_store;
  logic       unit_stride;
  logic       width_ok;
  logic [1:0] eew_sel;
  logic [6:0] seg_cnt;
  logic       legal;
  logic [31:0] elem_per_reg;

  assign is_store = (inst.ls.opcode == STORE);

  // only mop 0, mew 0 and lumop 0 are supported
  assign unit_stride = (inst.ls.mop == 2'b00) & ~inst.ls.mew & (inst.ls.lumop == 5'd0);

  // width field gives EEW of 8, 16, 32 or 64
  always_comb begin
    width_ok = 1'b1;
    case (inst.ls.width)
      3'b000:  eew_sel = 2'd0;
      3'b101:  eew_sel = 2'd1;
      3'b110:  eew_sel = 2'd2;
      3'b111:  eew_sel = 2'd3;
      default: begin
        eew_sel  = 2'd0;
        width_ok = 1'b0;
      end
    endcase
  end

  // fields times LMUL registers, up to 64 before the limit check
  assign seg_cnt = (7'(inst.ls.nf) + 7'd1) << vlmul;
  assign legal   = unit_stride & width_ok & (seg_cnt <= 7'(MAX_UOP));

  // elements per register at EEW
  assign elem_per_reg = 32'(VLEN) >> (32'd3 + 32'(eew_sel));

  always_comb begin
    logic [UOP_INDEX_WIDTH:0] idx;
    logic [31:0]              offset;
    for (int s = 0; s < NUM_DE_UOP; s++) begin
      idx    = (UOP_INDEX_WIDTH + 1)'(uop_index_remain) + (UOP_INDEX_WIDTH + 1)'(s);
      offset = 32'(idx) * elem_per_reg;

      uop_valid[s]    = inst_valid & legal & (7'(idx) < seg_cnt);
      uop_type[s]     = is_store ? UOP_STORE : UOP_LOAD;
      uop_index[s]    = idx[UOP_INDEX_WIDTH-1:0];
      // vs3 for stores, vd for loads, same field
      vd[s]           = inst.ls.vd + 5'(idx);
      // no vector sources
      vs1[s]          = '0;
      vs2[s]          = '0;
      // base address
      uop_rs1_data[s] = rs1_data;
      vm[s]           = inst.ls.vm;
      uop_vstart[s]   = (32'(vstart) > offset) ?
                        VSTART_WIDTH'(32'(vstart) - offset) : '0;
      last[s]         = (7'(idx) == seg_cnt - 7'd1);
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal \
       --top-module tb_rvv_decode -f src.f -o sim_rvv_decode \
  && { out="$(./obj_dir/sim_rvv_decode 2>&1)" || true; } \
  && printf '%s\n' "$out" \
  && printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS' \
  || { echo "simulation did not pass"; exit 1; }

//--- src.f
rtl/rvv_decode_pkg.sv
rtl/rvv_cmd_queue.sv
rtl/rvv_decode_unit_ari.sv
rtl/rvv_decode_unit_lsu.sv
rtl/rvv_decode_unit.sv
rtl/rvv_decode_ctrl.sv
rtl/rvv_decode_top.sv
tests/rvv_decode_checker.sv
tests/tb_rvv_decode.sv

//--- tests/rvv_decode_checker.sv
// bound assertions on the decode stage top-level ports
`timescale 1ns/1ps

module rvv_decode_checker
  import rvv_decode_pkg::*;
(
  input logic                  clk,
  input logic                  rst,
  input logic                  uq_room,
  input logic [NUM_DE_UOP-1:0] uop_valid,
  input logic                  inst_discard
);

  // valid slots fill from slot 0 with no holes
  valid_contiguous: assert property (@(posedge clk) disable iff (rst)
    (uop_valid & (uop_valid + 1'b1)) == '0)
    else $error("uop_valid has a hole: %b", uop_valid);

  // nothing leaves without room or while in reset
  valid_needs_room: assert property (@(posedge clk)
    (rst || !uq_room) |-> (uop_valid == '0))
    else $error("uop_valid %b without room or during reset", uop_valid);

  // a dropped command carries no uops
  discard_without_uops: assert property (@(posedge clk) disable iff (rst)
    inst_discard |-> (uop_valid == '0))
    else $error("inst_discard together with uop_valid %b", uop_valid);

endmodule

// every decode stage top gets a checker
bind rvv_decode_top rvv_decode_checker u_checker (
  .clk(clk),
  .rst(rst),
  .uq_room(uq_room),
  .uop_valid(uop_valid),
  .inst_discard(inst_discard)
);

//--- tests/tb_rvv_decode.sv
// testbench for the vector decode stage: command table, clock, reset, uop collection, checks
`timescale 1ns/1ps

module tb_rvv_decode
  import rvv_decode_pkg::*;
();

  localparam int VLEN     = 128;
  localparam int CQ_DEPTH = 4;
  localparam int ROWS     = 15;
  // 40 cycles per test, the queue fill included, plus the reset cycles
  localparam int LIMIT    = (ROWS + 1) * 40 + 5;

  logic                                       clk;
  logic                                       rst;
  logic                                       cmd_valid;
  rvv_inst_u                                  cmd_inst;
  logic [1:0]                                 cmd_vlmul;
  logic [1:0]                                 cmd_vsew;
  logic [VSTART_WIDTH-1:0]                    cmd_vstart;
  logic [31:0]                                cmd_rs1_data;
  logic                                       uq_room;
  logic [NUM_DE_UOP-1:0]                      uop_valid;
  uop_type_e [NUM_DE_UOP-1:0]                 uop_type;
  logic [NUM_DE_UOP-1:0][UOP_INDEX_WIDTH-1:0] uop_index;
  logic [NUM_DE_UOP-1:0][4:0]                 vd;
  logic [NUM_DE_UOP-1:0][4:0]                 vs1;
  logic [NUM_DE_UOP-1:0][4:0]                 vs2;
  logic [NUM_DE_UOP-1:0][31:0]                uop_rs1_data;
  logic [NUM_DE_UOP-1:0]                      vm;
  logic [NUM_DE_UOP-1:0][VSTART_WIDTH-1:0]    uop_vstart;
  logic [NUM_DE_UOP-1:0]                      last;
  logic                                       inst_discard;
  logic                                       cq_full;

  // command table, one row per test
  logic [31:0]             tab_inst   [ROWS];
  logic [1:0]              tab_vlmul  [ROWS];
  logic [1:0]              tab_vsew   [ROWS];
  logic [VSTART_WIDTH-1:0] tab_vstart [ROWS];
  logic [31:0]             tab_rs1    [ROWS];
  // expected uop count, 0 for a dropped command
  int                      tab_cnt    [ROWS];
  int                      tab_vd     [ROWS];
  uop_type_e               tab_type   [ROWS];

  int n_rows     = 0;
  int row_errors = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycles     = 0;

  rvv_decode_top #(.CQ_DEPTH(CQ_DEPTH), .VLEN(VLEN)) u_rvv_decode_top (.*);

  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // OP-V arithmetic word
  function automatic logic [31:0] encode_ari(input logic [5:0] funct6, input logic [2:0] funct3,
                                             input logic vm_bit, input logic [4:0] vd_f,
                                             input logic [4:0] vs2_f, input logic [4:0] vs1_f);
    return {funct6, vm_bit, vs2_f, vs1_f, funct3, vd_f, RVV};
  endfunction

  // load/store word, unmasked, lumop 0, base in x10
  function automatic logic [31:0] encode_ls(input logic [2:0] nf, input logic [1:0] mop,
                                            input logic [2:0] width, input logic [4:0] vd_f,
                                            input logic store);
    return {nf, 1'b0, mop, 1'b1, 5'd0, 5'd10, width, vd_f, store ? STORE : LOAD};
  endfunction

  task automatic add_row(input logic [31:0] inst, input logic [1:0] lmul, input logic [1:0] sew,
                         input logic [VSTART_WIDTH-1:0] vst, input logic [31:0] rs1,
                         input int cnt, input int vd_base, input uop_type_e typ);
    tab_inst[n_rows]   = inst;
    tab_vlmul[n_rows]  = lmul;
    tab_vsew[n_rows]   = sew;
    tab_vstart[n_rows] = vst;
    tab_rs1[n_rows]    = rs1;
    tab_cnt[n_rows]    = cnt;
    tab_vd[n_rows]     = vd_base;
    tab_type[n_rows]   = typ;
    n_rows++;
  endtask

  task automatic fill_table();
    // integer ops over LMUL 1, 2, 4, 8 and all three forms
    add_row(encode_ari(VADD, OPIVV, 1'b1, 5'd1, 5'd8, 5'd16),
            2'd0, 2'd0, 7'd0, 32'h0, 1, 1, UOP_ADD);
    add_row(encode_ari(VSUB, OPIVX, 1'b1, 5'd2, 5'd10, 5'd5),
            2'd1, 2'd1, 7'd0, 32'hdeadbeef, 2, 2, UOP_SUB);
    // imm5 of -10, scalar register ignored
    add_row(encode_ari(VAND, OPIVI, 1'b0, 5'd4, 5'd12, 5'b10110),
            2'd2, 2'd2, 7'd0, 32'h12345678, 4, 4, UOP_AND);
    add_row(encode_ari(VOR, OPIVV, 1'b1, 5'd8, 5'd16, 5'd24),
            2'd3, 2'd3, 7'd0, 32'h0, 8, 8, UOP_OR);
    add_row(encode_ari(VXOR, OPIVX, 1'b0, 5'd3, 5'd9, 5'd0),
            2'd0, 2'd0, 7'd0, 32'h0000a5a5, 1, 3, UOP_XOR);
    // widening, then widening with no room at LMUL 8
    add_row(encode_ari(VWADDU, OPMVV, 1'b1, 5'd8, 5'd4, 5'd12),
            2'd2, 2'd0, 7'd0, 32'h0, 8, 8, UOP_WADDU);
    add_row(encode_ari(VWADDU, OPMVV, 1'b1, 5'd0, 5'd8, 5'd16),
            2'd3, 2'd0, 7'd0, 32'h0, 0, 0, UOP_WADDU);
    // segment load and store, then too many segment registers
    add_row(encode_ls(3'd1, 2'b00, 3'b101, 5'd4, 1'b0),
            2'd1, 2'd0, 7'd0, 32'h1000, 4, 4, UOP_LOAD);
    add_row(encode_ls(3'd3, 2'b00, 3'b000, 5'd8, 1'b1),
            2'd1, 2'd0, 7'd0, 32'h2000, 8, 8, UOP_STORE);
    add_row(encode_ls(3'd3, 2'b00, 3'b000, 5'd0, 1'b0),
            2'd2, 2'd0, 7'd0, 32'h3000, 0, 0, UOP_LOAD);
    // 16 elements per register at SEW 8
    add_row(encode_ari(VADD, OPIVI, 1'b1, 5'd16, 5'd20, 5'd7),
            2'd2, 2'd0, 7'd40, 32'h0, 4, 16, UOP_ADD);
    // scalar add, illegal funct pair, strided load
    add_row(32'h002081b3, 2'd0, 2'd0, 7'd0, 32'h0, 0, 0, UOP_ADD);
    add_row(encode_ari(VWADDU, OPIVV, 1'b1, 5'd0, 5'd4, 5'd8),
            2'd0, 2'd0, 7'd0, 32'h0, 0, 0, UOP_WADDU);
    add_row(encode_ls(3'd0, 2'b10, 3'b110, 5'd2, 1'b0),
            2'd0, 2'd0, 7'd0, 32'h4000, 0, 0, UOP_LOAD);
    // EEW 32 from width, 4 elements per register
    add_row(encode_ls(3'd0, 2'b00, 3'b110, 5'd16, 1'b0),
            2'd3, 2'd0, 7'd20, 32'h5000, 8, 16, UOP_LOAD);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("mismatch %s: expected 0x%0h actual 0x%0h", name, expected, actual);
      row_errors++;
    end
  endtask

  // uop k of row r, seen in slot s
  task automatic check_uop(input int r, input int k, input int s);
    rvv_inst_u iw;
    string     sl;
    int        eew;
    int        step;
    int        src_k;
    int        vst;
    int        exp_vstart;
    int        imm;
    iw  = tab_inst[r];
    sl  = $sformatf("[%0d]", s);
    vst = tab_vstart[r];
    if (iw.ari.opcode == RVV) begin
      eew = 8 << tab_vsew[r];
    end else begin
      // width field overrides SEW
      case (iw.ls.width)
        3'b101:  eew = 16;
        3'b110:  eew = 32;
        3'b111:  eew = 64;
        default: eew = 8;
      endcase
    end
    step       = VLEN / eew;
    exp_vstart = (vst > k * step) ? vst - k * step : 0;
    src_k      = (tab_type[r] == UOP_WADDU) ? k / 2 : k;
    compare_value({"uop_index", sl}, k, uop_index[s]);
    compare_value({"uop_type", sl}, tab_type[r], uop_type[s]);
    compare_value({"vd", sl}, (tab_vd[r] + k) % 32, vd[s]);
    compare_value({"vm", sl}, iw.ari.vm, vm[s]);
    compare_value({"uop_vstart", sl}, exp_vstart, uop_vstart[s]);
    compare_value({"last", sl}, k == tab_cnt[r] - 1, last[s]);
    if (iw.ari.opcode == RVV) begin
      compare_value({"vs2", sl}, (iw.ari.vs2 + src_k) % 32, vs2[s]);
      if (iw.ari.funct3 inside {OPIVV, OPMVV}) begin
        compare_value({"vs1", sl}, (iw.ari.vs1 + src_k) % 32, vs1[s]);
      end else if (iw.ari.funct3 == OPIVX) begin
        compare_value({"uop_rs1_data", sl}, tab_rs1[r], uop_rs1_data[s]);
      end else begin
        // imm5 as a signed value
        imm = $signed(iw.ari.vs1);
        compare_value({"uop_rs1_data", sl}, imm, uop_rs1_data[s]);
      end
    end
  endtask

  // write one command, then collect uops until last or discard
  task automatic run_row(input int r);
    int   got;
    logic done;
    logic discarded;
    got        = 0;
    done       = 1'b0;
    discarded  = 1'b0;
    row_errors = 0;
    @(posedge clk);
    cmd_valid    <= 1'b1;
    cmd_inst     <= tab_inst[r];
    cmd_vlmul    <= tab_vlmul[r];
    cmd_vsew     <= tab_vsew[r];
    cmd_vstart   <= tab_vstart[r];
    cmd_rs1_data <= tab_rs1[r];
    uq_room      <= ($urandom % 4) != 0;
    @(posedge clk);
    cmd_valid <= 1'b0;
    uq_room   <= ($urandom % 4) != 0;
    while (!done) begin
      // outputs settled mid-cycle, valid slots are taken at the next edge
      @(negedge clk);
      if (inst_discard) begin
        discarded = 1'b1;
        done      = 1'b1;
      end
      for (int s = 0; s < NUM_DE_UOP; s++) begin
        if (uop_valid[s] && !done) begin
          check_uop(r, got, s);
          if (last[s]) begin
            done = 1'b1;
          end
          got++;
        end
      end
      if (!done) begin
        @(posedge clk);
        uq_room <= ($urandom % 4) != 0;
      end
    end
    compare_value("uop count", tab_cnt[r], got);
    assert (discarded == (tab_cnt[r] == 0)) else begin
      $display("test %0d: inst_discard %s", r,
               discarded ? "pulsed for a legal command" : "never pulsed for an illegal command");
      row_errors++;
    end
    $display("test %0d: %0d uops collected, discard %0d, %s", r, got, discarded,
             (row_errors == 0) ? "ok" : "error");
    if (row_errors == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  // fill the queue with row 0 while the uops queue has no room, one write too many
  task automatic check_queue_full(input int t);
    int lasts;
    lasts      = 0;
    row_errors = 0;
    for (int i = 0; i <= CQ_DEPTH; i++) begin
      @(posedge clk);
      cmd_valid    <= 1'b1;
      cmd_inst     <= tab_inst[0];
      cmd_vlmul    <= tab_vlmul[0];
      cmd_vsew     <= tab_vsew[0];
      cmd_vstart   <= tab_vstart[0];
      cmd_rs1_data <= tab_rs1[0];
      uq_room      <= 1'b0;
      // i commands stored by now
      @(negedge clk);
      compare_value("cq_full", i == CQ_DEPTH, cq_full);
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
    uq_room   <= 1'b1;
    // one single-uop command retires per cycle
    while (lasts < CQ_DEPTH) begin
      @(negedge clk);
      compare_value("cq_full", lasts == 0, cq_full);
      if (uop_valid[0]) begin
        check_uop(0, 0, 0);
        lasts++;
      end
      @(posedge clk);
    end
    // the write made while full left nothing behind
    @(negedge clk);
    compare_value("uop_valid", 0, uop_valid);
    $display("test %0d: %0d queued commands retired, %s", t, lasts,
             (row_errors == 0) ? "ok" : "error");
    if (row_errors == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    void'($urandom(32'h3bc6f1c3));
    clk          = 1'b0;
    rst          = 1'b1;
    cmd_valid    = 1'b0;
    cmd_inst     = '0;
    cmd_vlmul    = '0;
    cmd_vsew     = '0;
    cmd_vstart   = '0;
    cmd_rs1_data = '0;
    uq_room      = 1'b0;
    fill_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    check_queue_full(n_rows);
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
